//--- common/mipsPkg.sv
package mipsPkg;

	typedef enum logic [5:0] {
		opSpecial = 6'b000000,
		opJ       = 6'b000010,
		opJal     = 6'b000011,
		opBeq     = 6'b000100,
		opBne     = 6'b000101,
		opAddiu   = 6'b001001,
		opSlti    = 6'b001010,
		opSltiu   = 6'b001011,
		opAndi    = 6'b001100,
		opOri     = 6'b001101,
		opXori    = 6'b001110,
		opLui     = 6'b001111,
		opLw      = 6'b100011,
		opSw      = 6'b101011
	} opcodeE;

	typedef enum logic [5:0] {
		fnSll     = 6'b000000,
		fnSrl     = 6'b000010,
		fnSra     = 6'b000011,
		fnJr      = 6'b001000,
		fnJalr    = 6'b001001,
		fnSyscall = 6'b001100,
		fnAddu    = 6'b100001,
		fnSubu    = 6'b100011,
		fnAnd     = 6'b100100,
		fnOr      = 6'b100101,
		fnXor     = 6'b100110,
		fnNor     = 6'b100111,
		fnSlt     = 6'b101010,
		fnSltu    = 6'b101011
	} functE;

	typedef enum logic [3:0] {
		aluAdd, aluSub, aluAnd, aluOr, aluXor, aluNor,
		aluSlt, aluSltu, aluSll, aluSrl, aluSra, aluLui
	} aluOpE;

	typedef struct packed {
		logic  regDst;
		logic  link;     // write pc+4 to r31 (jal) or rd (jalr)
		logic  jump;
		logic  jumpReg;
		logic  branch;
		logic  branchNe;
		logic  memRead;
		logic  memWrite;
		logic  memToReg;
		logic  regWrite;
		logic  aluSrc;
		logic  zeroExt;
		logic  shiftImm;
		logic  halt;
		logic  illegal;
		aluOpE aluOp;
	} ctrlT;

	typedef enum logic [2:0] {
		stFetch, stDecode, stExecute, stMemAccess, stWriteBack, stHalted
	} coreStateE;

	typedef enum logic [2:0] {
		arbIdle, arbReadAddr, arbReadData, arbWriteAddr, arbWriteResp
	} arbStateE;

	typedef struct packed {
		logic        valid;
		logic        write;
		logic [31:0] addr;
		logic [31:0] wdata;
	} memReqT;

	typedef struct packed {
		logic        done;  // single cycle
		logic [31:0] rdata;
	} memRspT;

	typedef struct packed {
		logic        awvalid;
		logic [31:0] awaddr;
		logic        wvalid;
		logic [31:0] wdata;
		logic [3:0]  wstrb;
		logic        bready;
		logic        arvalid;
		logic [31:0] araddr;
		logic        rready;
	} axiReqT;

	typedef struct packed {
		logic        awready;
		logic        wready;
		logic        bvalid;
		logic [1:0]  bresp;
		logic        arready;
		logic        rvalid;
		logic [31:0] rdata;
		logic [1:0]  rresp;
	} axiRspT;

endpackage

//--- hdl/control.sv
`timescale 1ns/10ps

module control import mipsPkg::*; (
	input  opcodeE insop,
	input  functE  func,
	output ctrlT   ctrl
);

	always_comb begin
		ctrl = '0;
		ctrl.aluOp = aluAdd;
		case (insop)
		opSpecial: begin
			ctrl.regDst = 1'b1;
			ctrl.regWrite = 1'b1;
			case (func)
			fnAddu: ctrl.aluOp = aluAdd;
			fnSubu: ctrl.aluOp = aluSub;
			fnAnd:  ctrl.aluOp = aluAnd;
			fnOr:   ctrl.aluOp = aluOr;
			fnXor:  ctrl.aluOp = aluXor;
			fnNor:  ctrl.aluOp = aluNor;
			fnSlt:  ctrl.aluOp = aluSlt;
			fnSltu: ctrl.aluOp = aluSltu;
			fnSll: begin
				ctrl.aluOp = aluSll;
				ctrl.shiftImm = 1'b1;
			end
			fnSrl: begin
				ctrl.aluOp = aluSrl;
				ctrl.shiftImm = 1'b1;
			end
			fnSra: begin
				ctrl.aluOp = aluSra;
				ctrl.shiftImm = 1'b1;
			end
			fnJr: begin
				ctrl.regDst = 1'b0;
				ctrl.regWrite = 1'b0;
				ctrl.jumpReg = 1'b1;
			end
			fnJalr: begin
				ctrl.jumpReg = 1'b1;
				ctrl.link = 1'b1; // return address goes to rd
			end
			fnSyscall: begin
				ctrl.regWrite = 1'b0;
				ctrl.halt = 1'b1;
			end
			default: begin
				ctrl.regWrite = 1'b0;
				ctrl.illegal = 1'b1;
			end
			endcase
		end
		opJ: ctrl.jump = 1'b1;
		opJal: begin
			ctrl.jump = 1'b1;
			ctrl.link = 1'b1;
			ctrl.regWrite = 1'b1;
		end
		opBeq, opBne: begin
			ctrl.branch = 1'b1;
			ctrl.branchNe = (insop == opBne);
			ctrl.aluOp = aluSub; // compare through zero flag
		end
		opAddiu, opSlti, opSltiu, opAndi, opOri, opXori, opLui: begin
			ctrl.aluSrc = 1'b1;
			ctrl.regWrite = 1'b1;
			case (insop)
			opSlti:  ctrl.aluOp = aluSlt;
			opSltiu: ctrl.aluOp = aluSltu;
			opAndi:  ctrl.aluOp = aluAnd;
			opOri:   ctrl.aluOp = aluOr;
			opXori:  ctrl.aluOp = aluXor;
			opLui:   ctrl.aluOp = aluLui;
			default: ctrl.aluOp = aluAdd;
			endcase
			ctrl.zeroExt = (insop == opAndi) || (insop == opOri) || (insop == opXori);
		end
		opLw: begin
			ctrl.aluSrc = 1'b1;
			ctrl.memRead = 1'b1;
			ctrl.memToReg = 1'b1;
			ctrl.regWrite = 1'b1;
		end
		opSw: begin
			ctrl.aluSrc = 1'b1;
			ctrl.memWrite = 1'b1;
		end
		default: ctrl.illegal = 1'b1;
		endcase
	end

endmodule

//--- hdl/aluUnit.sv
`timescale 1ns/10ps

module aluUnit import mipsPkg::*; (
	input  aluOpE       aluOp,
	input  logic [31:0] a,
	input  logic [31:0] b,
	input  logic [4:0]  shamt,
	output logic [31:0] result,
	output logic        zero
);

	always_comb begin
		case (aluOp)
		aluAdd:  result = a + b;
		aluSub:  result = a - b;
		aluAnd:  result = a & b;
		aluOr:   result = a | b;
		aluXor:  result = a ^ b;
		aluNor:  result = ~(a | b);
		aluSlt:  result = {31'b0, $signed(a) < $signed(b)};
		aluSltu: result = {31'b0, a < b};
		aluSll:  result = b << shamt;
		aluSrl:  result = b >> shamt;
		aluSra:  result = 32'($signed(b) >>> shamt);
		aluLui:  result = {b[15:0], 16'h0000};
		default: result = a + b;
		endcase
	end

	assign zero = (result == 32'd0); // beq/bne via aluSub

endmodule

//--- hdl/regFile.sv
`timescale 1ns/10ps

module regFile (
	input  logic        clk,
	input  logic        rstN,
	input  logic [4:0]  rdAddrA,
	input  logic [4:0]  rdAddrB,
	output logic [31:0] rdDataA,
	output logic [31:0] rdDataB,
	input  logic        wrEn,
	input  logic [4:0]  wrAddr,
	input  logic [31:0] wrData
);

	logic [31:0] regs [32];

	always_ff @(posedge clk) begin
		if (!rstN) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= 32'd0;
			end
		end else if (wrEn && (wrAddr != 5'd0)) begin // r0 stays zero
			regs[wrAddr] <= wrData;
		end
	end

	assign rdDataA = regs[rdAddrA];
	assign rdDataB = regs[rdAddrB];

endmodule

//--- hdl/cpuCore.sv
`timescale 1ns/10ps

module cpuCore import mipsPkg::*; #(
	parameter int unsigned CoreId = 0,
	parameter logic [31:0] CoreStride = 32'h1000
) (
	input  logic   clk,
	input  logic   rstN,
	output memReqT memReq,
	input  memRspT memRsp,
	output logic   halted
);

	coreStateE state;
	logic [31:0] pc, ir, nextPc, opA, opB, aluRes, loadData;
	logic [31:0] pcPlus4, imm, aluB, aluOut, brTarget, wrData, rdDataA, rdDataB;
	logic [4:0] wrAddr, shamt;
	logic aluZero, taken, wrEn;
	ctrlT ctrl;
	opcodeE insop;
	functE func;

	assign insop = opcodeE'(ir[31:26]);
	assign func = functE'(ir[5:0]);

	control uControl (.insop(insop), .func(func), .ctrl(ctrl));

	assign imm = ctrl.zeroExt ? {16'h0000, ir[15:0]} : {{16{ir[15]}}, ir[15:0]};
	assign aluB = ctrl.aluSrc ? imm : opB;
	assign shamt = ctrl.shiftImm ? ir[10:6] : opA[4:0];

	aluUnit uAlu (
		.aluOp(ctrl.aluOp),
		.a(opA),
		.b(aluB),
		.shamt(shamt),
		.result(aluOut),
		.zero(aluZero)
	);

	assign pcPlus4 = pc + 32'd4;
	assign brTarget = pcPlus4 + {imm[29:0], 2'b00};
	assign taken = ctrl.branch && (aluZero != ctrl.branchNe);

	assign wrEn = (state == stWriteBack) && ctrl.regWrite;
	assign wrAddr = (ctrl.link && !ctrl.regDst) ? 5'd31 : (ctrl.regDst ? ir[15:11] : ir[20:16]);
	assign wrData = ctrl.link ? pcPlus4 : (ctrl.memToReg ? loadData : aluRes);

	regFile uRegs (
		.clk(clk),
		.rstN(rstN),
		.rdAddrA(ir[25:21]),
		.rdAddrB(ir[20:16]),
		.rdDataA(rdDataA),
		.rdDataB(rdDataB),
		.wrEn(wrEn),
		.wrAddr(wrAddr),
		.wrData(wrData)
	);

	assign halted = (state == stHalted);

	always_ff @(posedge clk) begin
		if (!rstN) begin
			state <= stFetch;
			pc <= 32'(CoreId) * CoreStride;
			memReq.valid <= 1'b0;
		end else begin
			case (state)
			stFetch: begin
				if (memRsp.done) begin
					ir <= memRsp.rdata;
					memReq.valid <= 1'b0;
					state <= stDecode;
				end else if (!memReq.valid) begin // first fetch after reset
					memReq <= '{valid: 1'b1, write: 1'b0, addr: pc, wdata: 32'd0};
				end
			end
			stDecode: begin
				opA <= rdDataA;
				opB <= rdDataB;
				state <= (ctrl.halt || ctrl.illegal) ? stHalted : stExecute;
			end
			stExecute: begin
				aluRes <= aluOut;
				if (ctrl.jumpReg)
					nextPc <= opA;
				else if (ctrl.jump)
					nextPc <= {pcPlus4[31:28], ir[25:0], 2'b00};
				else if (taken)
					nextPc <= brTarget;
				else
					nextPc <= pcPlus4;
				if (ctrl.memRead || ctrl.memWrite) begin
					memReq <= '{valid: 1'b1, write: ctrl.memWrite, addr: aluOut, wdata: opB};
					state <= stMemAccess;
				end else begin
					state <= stWriteBack;
				end
			end
			stMemAccess: begin
				if (memRsp.done) begin
					loadData <= memRsp.rdata;
					memReq.valid <= 1'b0;
					state <= stWriteBack;
				end
			end
			stWriteBack: begin
				pc <= nextPc;
				memReq <= '{valid: 1'b1, write: 1'b0, addr: nextPc, wdata: 32'd0};
				state <= stFetch;
			end
			default: state <= stHalted; // syscall or illegal, no way out
			endcase
		end
	end

	// request must hold until the arbiter answers
	assert property (@(posedge clk) disable iff (!rstN)
		memReq.valid && !memRsp.done |=> memReq.valid && $stable(memReq.write)
			&& $stable(memReq.addr) && $stable(memReq.wdata));

	assert property (@(posedge clk) disable iff (!rstN) memRsp.done |-> memReq.valid);

endmodule

//--- hdl/memArbiter.sv
`timescale 1ns/10ps

module memArbiter import mipsPkg::*; #(
	parameter int unsigned NumCores = 2
) (
	input  logic   clk,
	input  logic   rstN,
	input  memReqT coreReq [NumCores],
	output memRspT coreRsp [NumCores],
	output axiReqT axiReq,
	input  axiRspT axiRsp
);

	localparam int unsigned IdxW = (NumCores > 1) ? $clog2(NumCores) : 1;

	arbStateE state;
	logic [IdxW-1:0] ptr, grant, pick;
	logic found, awPend, wPend, doneQ;
	logic [31:0] rdataQ;
	logic [NumCores-1:0] doneVec;
	memReqT held;

	// first requester at or after ptr, wrapping
	always_comb begin
		int unsigned idx;
		found = 1'b0;
		pick = ptr;
		for (int unsigned k = 0; k < NumCores; k++) begin
			idx = (ptr + k) % NumCores;
			if (!found && coreReq[idx].valid) begin
				found = 1'b1;
				pick = IdxW'(idx);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			state <= arbIdle;
			ptr <= '0;
			doneQ <= 1'b0;
			awPend <= 1'b0;
			wPend <= 1'b0;
		end else begin
			doneQ <= 1'b0;
			case (state)
			arbIdle: begin
				if (found && !doneQ) begin // finished core still shows valid this cycle
					held <= coreReq[pick];
					grant <= pick;
					ptr <= (pick == IdxW'(NumCores - 1)) ? '0 : pick + 1'b1;
					awPend <= coreReq[pick].write;
					wPend <= coreReq[pick].write;
					state <= coreReq[pick].write ? arbWriteAddr : arbReadAddr;
				end
			end
			arbReadAddr: if (axiRsp.arready) state <= arbReadData;
			arbReadData: begin
				if (axiRsp.rvalid) begin
					rdataQ <= axiRsp.rdata;
					doneQ <= 1'b1;
					state <= arbIdle;
				end
			end
			arbWriteAddr: begin
				if (axiRsp.awready) awPend <= 1'b0;
				if (axiRsp.wready) wPend <= 1'b0;
				if ((!awPend || axiRsp.awready) && (!wPend || axiRsp.wready))
					state <= arbWriteResp;
			end
			arbWriteResp: begin
				if (axiRsp.bvalid) begin
					doneQ <= 1'b1;
					state <= arbIdle;
				end
			end
			default: state <= arbIdle;
			endcase
		end
	end

	always_comb begin
		axiReq.awvalid = (state == arbWriteAddr) && awPend;
		axiReq.awaddr = held.addr;
		axiReq.wvalid = (state == arbWriteAddr) && wPend;
		axiReq.wdata = held.wdata;
		axiReq.wstrb = 4'hf; // full words only
		axiReq.bready = (state == arbWriteResp);
		axiReq.arvalid = (state == arbReadAddr);
		axiReq.araddr = held.addr;
		axiReq.rready = (state == arbReadData);
	end

	always_comb begin
		for (int unsigned i = 0; i < NumCores; i++) begin
			doneVec[i] = doneQ && (grant == IdxW'(i));
			coreRsp[i].done = doneVec[i];
			coreRsp[i].rdata = rdataQ;
		end
	end

	assert property (@(posedge clk) disable iff (!rstN) !(axiReq.arvalid && axiReq.awvalid));

	assert property (@(posedge clk) disable iff (!rstN)
		axiReq.arvalid && !axiRsp.arready |=> $stable(axiReq.araddr));

	assert property (@(posedge clk) disable iff (!rstN) $onehot0(doneVec));

endmodule

//--- hdl/mipsTop.sv
`timescale 1ns/10ps

module mipsTop import mipsPkg::*; #(
	parameter int unsigned NumCores = 2,
	parameter logic [31:0] CoreStride = 32'h1000
) (
	input  logic                clk,
	input  logic                rstN,
	output axiReqT              axiReq,
	input  axiRspT              axiRsp,
	output logic [NumCores-1:0] halted
);

	memReqT coreReq [NumCores];
	memRspT coreRsp [NumCores];

	for (genvar i = 0; i < NumCores; i++) begin : gCore
		cpuCore #(
			.CoreId(i),
			.CoreStride(CoreStride)
		) uCore (
			.clk(clk),
			.rstN(rstN),
			.memReq(coreReq[i]),
			.memRsp(coreRsp[i]),
			.halted(halted[i])
		);
	end

	memArbiter #(
		.NumCores(NumCores)
	) uArbiter (
		.clk(clk),
		.rstN(rstN),
		.coreReq(coreReq),
		.coreRsp(coreRsp),
		.axiReq(axiReq),
		.axiRsp(axiRsp)
	);

endmodule

//--- dv/axiMemModel.sv
`timescale 1ns/10ps

module axiMemModel import mipsPkg::*; #(
	parameter int Words = 2048
) (
	input  logic        clk,
	input  logic        rstN,
	input  axiReqT      axiReq,
	output axiRspT      axiRsp,
	output logic        logged,  // one cycle per committed store
	output logic [31:0] logAddr,
	output logic [31:0] logData
);

	logic [31:0] mem [Words];
	logic [31:0] rdAddr, wrAddr, wrData;
	logic rdPend, awGot, wGot, bPend;
	int arWait, rWait, awWait, wWait, bWait;

	function automatic int delay();
		return int'($urandom_range(0, 3));
	endfunction

	function automatic int wordIndex(logic [31:0] addr);
		return int'(addr >> 2) % Words;
	endfunction

	initial begin
		axiRsp = '0;
		logged = 1'b0;
	end

	always @(posedge clk) begin
		if (!rstN) begin
			axiRsp <= '0;
			logged <= 1'b0;
			rdPend <= 1'b0;
			awGot <= 1'b0;
			wGot <= 1'b0;
			bPend <= 1'b0;
			arWait <= delay();
			rWait <= delay();
			awWait <= delay();
			wWait <= delay();
			bWait <= delay();
		end else begin
			axiRsp.arready <= 1'b0;
			axiRsp.awready <= 1'b0;
			axiRsp.wready <= 1'b0;
			logged <= 1'b0;
			if (axiReq.arvalid && axiRsp.arready) begin
				rdAddr <= axiReq.araddr;
				rdPend <= 1'b1;
				arWait <= delay();
			end else if (axiReq.arvalid && !rdPend) begin
				if (arWait == 0)
					axiRsp.arready <= 1'b1;
				else
					arWait <= arWait - 1;
			end
			if (axiRsp.rvalid && axiReq.rready) begin
				axiRsp.rvalid <= 1'b0;
				rdPend <= 1'b0;
				rWait <= delay();
			end else if (rdPend && !axiRsp.rvalid) begin
				if (rWait == 0) begin
					axiRsp.rvalid <= 1'b1;
					axiRsp.rdata <= mem[wordIndex(rdAddr)];
				end else begin
					rWait <= rWait - 1;
				end
			end
			if (axiReq.awvalid && axiRsp.awready) begin
				wrAddr <= axiReq.awaddr;
				awGot <= 1'b1;
				awWait <= delay();
			end else if (axiReq.awvalid && !awGot) begin
				if (awWait == 0)
					axiRsp.awready <= 1'b1;
				else
					awWait <= awWait - 1;
			end
			if (axiReq.wvalid && axiRsp.wready) begin
				wrData <= axiReq.wdata;
				wGot <= 1'b1;
				wWait <= delay();
			end else if (axiReq.wvalid && !wGot) begin
				if (wWait == 0)
					axiRsp.wready <= 1'b1;
				else
					wWait <= wWait - 1;
			end
			if (awGot && wGot) begin // full word, strobes are all ones
				mem[wordIndex(wrAddr)] <= wrData;
				logged <= 1'b1;
				logAddr <= wrAddr;
				logData <= wrData;
				awGot <= 1'b0;
				wGot <= 1'b0;
				bPend <= 1'b1;
			end
			if (axiRsp.bvalid && axiReq.bready) begin
				axiRsp.bvalid <= 1'b0;
				bWait <= delay();
			end else if (bPend && !axiRsp.bvalid) begin
				if (bWait == 0) begin
					axiRsp.bvalid <= 1'b1;
					bPend <= 1'b0;
				end else begin
					bWait <= bWait - 1;
				end
			end
		end
	end

endmodule

//--- dv/tbMips.sv
`timescale 1ns/10ps

module tbMips import mipsPkg::*; ();

	localparam int NumCores = 2;
	localparam logic [31:0] Stride = 32'h1000;
	localparam int Words = 2048;
	localparam int ProgLen = 42;  // base setup, 40 random slots, syscall
	localparam int DataOff = 32'h800;
	localparam int DataWords = 64;  // 256-byte data area
	localparam int TimeoutCycles = 40 * 2 * 30;

	logic clk, rstN;
	axiReqT axiReq;
	axiRspT axiRsp;
	logic [NumCores-1:0] halted;
	logic logged;
	logic [31:0] logAddr, logData;

	logic [31:0] image [Words];
	logic [31:0] refMem [NumCores][Words];
	logic [31:0] readQ [NumCores][$];  // fetch and load addresses in order
	logic [31:0] storeAddrQ [NumCores][$];
	logic [31:0] storeDataQ [NumCores][$];
	bit isJr [ProgLen];

	axiReqT prevReq;
	axiRspT prevRsp;
	bit open, seenAr;
	int arCount;
	logic [31:0] firstAr;

	mipsTop #(.NumCores(NumCores), .CoreStride(Stride)) uut (
		.clk(clk),
		.rstN(rstN),
		.axiReq(axiReq),
		.axiRsp(axiRsp),
		.halted(halted)
	);

	axiMemModel #(.Words(Words)) uMem (
		.clk(clk),
		.rstN(rstN),
		.axiReq(axiReq),
		.axiRsp(axiRsp),
		.logged(logged),
		.logAddr(logAddr),
		.logData(logData)
	);

	task automatic abortRun();
		$display("Something failed");
		$fatal(1, "simulation stopped");
	endtask

	task automatic reportMismatch(input string msg);
		$display("Error at %0t: %s", $time, msg);
		abortRun();
	endtask

	function automatic int wordIndex(logic [31:0] addr);
		return int'(addr >> 2) % Words;
	endfunction

	function automatic logic [31:0] rType(int rs, int rt, int rd, int sh, functE fn);
		return {6'b000000, 5'(rs), 5'(rt), 5'(rd), 5'(sh), fn};
	endfunction

	function automatic logic [31:0] iType(opcodeE op, int rs, int rt, logic [15:0] imm);
		return {op, 5'(rs), 5'(rt), imm};
	endfunction

	// never lands on a jr slot, whose register is set by the slot before it
	function automatic int forwardTarget(int lo);
		int t;
		t = int'($urandom_range(lo, ProgLen - 1));
		while (isJr[t])
			t++;
		return t;
	endfunction

	task automatic genProgram(input int c);
		functE rOps [11] = '{fnAddu, fnSubu, fnAnd, fnOr, fnXor, fnNor, fnSlt, fnSltu,
			fnSll, fnSrl, fnSra};
		opcodeE iOps [7] = '{opAddiu, opSlti, opSltiu, opAndi, opOri, opXori, opLui};
		int kindOf [ProgLen];
		int base, i, rs, rt, rd, t, fnIdx;
		logic [31:0] ins;
		base = int'(c * Stride / 4);
		for (i = 0; i < ProgLen; i++)
			isJr[i] = 1'b0;
		i = 1;
		while (i < ProgLen - 1) begin
			kindOf[i] = int'($urandom_range(0, 9));
			if (kindOf[i] == 8 && i < ProgLen - 2) begin
				kindOf[i + 1] = 10;  // jr or jalr through r26
				isJr[i + 1] = 1'b1;
				i += 2;
			end else begin
				if (kindOf[i] == 8)
					kindOf[i] = 0;
				i++;
			end
		end
		image[base] = iType(opAddiu, 0, 28, 16'(c * Stride + DataOff));  // r28 holds data base
		for (i = 1; i < ProgLen - 1; i++) begin
			rs = int'($urandom_range(0, 31));
			rt = int'($urandom_range(0, 31));
			rd = int'($urandom_range(1, 25));
			case (kindOf[i])
			0, 1, 9: begin
				fnIdx = int'($urandom_range(0, 10));
				ins = rType(rs, rt, rd, (fnIdx >= 8) ? int'($urandom_range(0, 31)) : 0,
					rOps[fnIdx]);
			end
			2, 3: ins = iType(iOps[$urandom_range(0, 6)], rs, rd, 16'($urandom));
			4: ins = iType(opLw, 28, rd, 16'($urandom_range(0, DataWords - 1) * 4));
			5: ins = iType(opSw, 28, rt, 16'($urandom_range(0, DataWords - 1) * 4));
			6: begin
				t = forwardTarget(i + 1);
				ins = iType($urandom_range(0, 1) ? opBne : opBeq, rs, rt, 16'(t - i - 1));
			end
			7: begin
				t = forwardTarget(i + 1);
				ins = {($urandom_range(0, 1) ? opJal : opJ), 26'(base + t)};
			end
			8: begin
				t = forwardTarget(i + 2);
				ins = iType(opAddiu, 0, 26, 16'((base + t) * 4));
			end
			default: begin
				if ($urandom_range(0, 1))
					ins = rType(26, 0, rd, 0, fnJalr);
				else
					ins = rType(26, 0, 0, 0, fnJr);
			end
			endcase
			image[base + i] = ins;
		end
		image[base + ProgLen - 1] = rType(0, 0, 0, 0, fnSyscall);
	endtask

	task automatic runModel(input int c);
		logic [31:0] r [32];
		logic [31:0] pc, ins, a, b, sImm, zImm, val, addr, nextPc;
		int k, dst, steps;
		bit stop;
		for (k = 0; k < 32; k++)
			r[k] = 32'd0;
		for (k = 0; k < Words; k++)
			refMem[c][k] = image[k];
		pc = c * Stride;
		stop = 1'b0;
		steps = 0;
		while (!stop && steps < 1000) begin
			readQ[c].push_back(pc);
			ins = refMem[c][wordIndex(pc)];
			a = r[ins[25:21]];
			b = r[ins[20:16]];
			sImm = {{16{ins[15]}}, ins[15:0]};
			zImm = {16'h0000, ins[15:0]};
			nextPc = pc + 32'd4;
			dst = int'(ins[20:16]);  // I-type destination
			val = 32'd0;
			case (ins[31:26])
			opSpecial: begin
				dst = int'(ins[15:11]);
				case (ins[5:0])
				fnAddu: val = a + b;
				fnSubu: val = a - b;
				fnAnd: val = a & b;
				fnOr: val = a | b;
				fnXor: val = a ^ b;
				fnNor: val = ~(a | b);
				fnSlt: val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
				fnSltu: val = (a < b) ? 32'd1 : 32'd0;
				fnSll: val = b << ins[10:6];
				fnSrl: val = b >> ins[10:6];
				fnSra: val = $signed(b) >>> ins[10:6];
				fnJalr: begin
					val = pc + 32'd4;
					nextPc = a;
				end
				fnJr: begin
					dst = 0;
					nextPc = a;
				end
				fnSyscall: begin
					dst = 0;
					stop = 1'b1;
				end
				default: reportMismatch("generator produced an unknown function code");
				endcase
			end
			opAddiu: val = a + sImm;
			opSlti: val = ($signed(a) < $signed(sImm)) ? 32'd1 : 32'd0;
			opSltiu: val = (a < sImm) ? 32'd1 : 32'd0;
			opAndi: val = a & zImm;
			opOri: val = a | zImm;
			opXori: val = a ^ zImm;
			opLui: val = {ins[15:0], 16'h0000};
			opLw: begin
				addr = a + sImm;
				readQ[c].push_back(addr);
				val = refMem[c][wordIndex(addr)];
			end
			opSw: begin
				dst = 0;
				addr = a + sImm;
				storeAddrQ[c].push_back(addr);
				storeDataQ[c].push_back(b);
				refMem[c][wordIndex(addr)] = b;
			end
			opBeq, opBne: begin
				dst = 0;
				if ((a == b) == (ins[31:26] == opBeq))
					nextPc = pc + 32'd4 + (sImm << 2);
			end
			opJ, opJal: begin
				dst = (ins[31:26] == opJal) ? 31 : 0;
				val = pc + 32'd4;
				nextPc = {nextPc[31:28], ins[25:0], 2'b00};
			end
			default: reportMismatch("generator produced an unknown opcode");
			endcase
			if (dst != 0)
				r[dst] = val;
			pc = nextPc;
			steps++;
		end
		if (!stop)
			reportMismatch($sformatf("model of core %0d never reached syscall", c));
	endtask

	task automatic checkFinal();
		int c, k, idx;
		for (c = 0; c < NumCores; c++) begin
			assert (readQ[c].size() == 0 && storeAddrQ[c].size() == 0)
			else reportMismatch($sformatf("core %0d halted with %0d reads, %0d stores missing",
				c, readQ[c].size(), storeAddrQ[c].size()));
			for (k = 0; k < DataWords; k++) begin
				idx = wordIndex(c * Stride + DataOff) + k;
				assert (uMem.mem[idx] === refMem[c][idx])
				else reportMismatch($sformatf("word %h is %h, model has %h",
					idx * 4, uMem.mem[idx], refMem[c][idx]));
			end
		end
	endtask

	always @(negedge clk) begin : monitor
		int c;
		logic [31:0] expAddr, expData;
		if (!rstN) begin
			prevReq = '0;
			prevRsp = '0;
			open = 1'b0;
			seenAr = 1'b0;
			arCount = 0;
		end else begin
			if (!seenAr) begin
				assert (halted == '0) else reportMismatch("halted set before the first fetch");
				seenAr = axiReq.arvalid;
			end
			if (axiReq.arvalid && axiRsp.arready) begin
				c = int'(axiReq.araddr / Stride);
				if (arCount == 0)
					firstAr = axiReq.araddr;
				if (arCount < 2) begin
					assert ((axiReq.araddr == 0 || axiReq.araddr == Stride)
						&& (arCount == 0 || axiReq.araddr != firstAr))
					else reportMismatch($sformatf("first fetch at %h", axiReq.araddr));
				end
				arCount++;
				assert (c < NumCores && readQ[c].size() > 0)
				else reportMismatch($sformatf("unexpected read at %h", axiReq.araddr));
				expAddr = readQ[c].pop_front();
				assert (axiReq.araddr == expAddr)
				else reportMismatch($sformatf("core %0d read %h, expected %h",
					c, axiReq.araddr, expAddr));
			end
			if (logged) begin
				c = int'(logAddr / Stride);
				assert (c < NumCores && storeAddrQ[c].size() > 0)
				else reportMismatch($sformatf("unexpected store to %h", logAddr));
				expAddr = storeAddrQ[c].pop_front();
				expData = storeDataQ[c].pop_front();
				assert (logAddr == expAddr && logData == expData)
				else reportMismatch($sformatf("core %0d stored %h to %h, expected %h to %h",
					c, logData, logAddr, expData, expAddr));
			end
			if (axiReq.wvalid) begin
				assert (axiReq.wstrb == 4'hf)
				else reportMismatch($sformatf("wstrb is %h on a full-word store", axiReq.wstrb));
			end
			if (prevReq.arvalid && !prevRsp.arready) begin
				assert (axiReq.arvalid && axiReq.araddr == prevReq.araddr)
				else reportMismatch("arvalid dropped or araddr moved before arready");
			end
			if (prevReq.awvalid && !prevRsp.awready) begin
				assert (axiReq.awvalid && axiReq.awaddr == prevReq.awaddr)
				else reportMismatch("awvalid dropped or awaddr moved before awready");
			end
			if (prevReq.wvalid && !prevRsp.wready) begin
				assert (axiReq.wvalid && axiReq.wdata == prevReq.wdata)
				else reportMismatch("wvalid dropped or wdata moved before wready");
			end
			assert (!(open && (axiReq.arvalid || axiReq.awvalid)))
			else reportMismatch("new address issued while a response was pending");
			if ((axiReq.arvalid && axiRsp.arready) || (axiReq.awvalid && axiRsp.awready))
				open = 1'b1;
			if ((axiRsp.rvalid && axiReq.rready) || (axiRsp.bvalid && axiReq.bready))
				open = 1'b0;
			prevReq = axiReq;
			prevRsp = axiRsp;
		end
	end

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	initial begin
		int k, cycles;
		rstN = 1'b0;
		void'($urandom(32'h7103));
		for (k = 0; k < Words; k++)
			image[k] = 32'ha5a5_0000 ^ (32'(k) << 2);  // byte address in the low half
		for (k = 0; k < NumCores; k++)
			genProgram(k);
		for (k = 0; k < NumCores; k++)
			runModel(k);
		for (k = 0; k < Words; k++)
			uMem.mem[k] = image[k];
		repeat (8) @(posedge clk);
		rstN <= 1'b1;
		cycles = 0;
		while (halted != '1 && cycles < TimeoutCycles) begin
			@(negedge clk);
			cycles++;
		end
		if (halted != '1) begin
			$display("the cores did not halt within %0d cycles", TimeoutCycles);
			abortRun();
		end else begin
			checkFinal();
			$display("Everything OK");
			$finish;
		end
	end

endmodule

//--- sources.f
common/mipsPkg.sv
hdl/control.sv
hdl/aluUnit.sv
hdl/regFile.sv
hdl/cpuCore.sv
hdl/memArbiter.sv
hdl/mipsTop.sv
dv/axiMemModel.sv
dv/tbMips.sv

//--- Bender.yml
package:
  name: mips_subsystem

sources:
  - common/mipsPkg.sv
  - hdl/control.sv
  - hdl/aluUnit.sv
  - hdl/regFile.sv
  - hdl/cpuCore.sv
  - hdl/memArbiter.sv
  - hdl/mipsTop.sv
  - target: simulation
    files:
      - dv/axiMemModel.sv
      - dv/tbMips.sv
